// ==== tb.f ====
tdc_pkg.sv
tdc_word_scan.sv
tdc_measure.sv
tdc_pack.sv
tdc_out_fifo.sv
tdc_core_top.sv
tb_tdc_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_tdc_core
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_tdc_core.sv ====
// Testbench for the TDC core, pulse streams checked against a reference model
`timescale 1ns/1ps

module tb_tdc_core;
    import tdc_pkg::*;

    localparam int SAMPLE_BITS = 16;
    localparam int FIFO_DEPTH  = 8;
    localparam int N_PULSES    = 34 + FIFO_DEPTH + 4;    // Pulses sent over all tests
    localparam int WD_CYCLES   = 50 * N_PULSES + 1000;

    logic                   DV_CLK;
    logic                   RST_SYNC;
    tdc_cfg_t               cfg;
    logic                   ext_en;
    logic                   arm;
    logic [15:0]            timestamp;
    logic                   samples_valid;
    logic [SAMPLE_BITS-1:0] tdc_samples;
    logic [SAMPLE_BITS-1:0] trig_samples;
    tdc_word_u              out_word;
    logic                   out_valid;
    logic                   out_ready;
    logic [31:0]            event_count;
    logic [7:0]             lost_count;

    bit          tdc_bits[$];   // Sample stream of one pulse, earliest first
    bit          trig_bits[$];
    tdc_word_u   exp_q[$];      // Expected records in output order
    logic [31:0] n_events;      // Model of event_count

    tdc_core_top #(.SAMPLE_BITS(SAMPLE_BITS), .FIFO_DEPTH(FIFO_DEPTH)) u_tdc_core_top (
        .DV_CLK        (DV_CLK),
        .RST_SYNC      (RST_SYNC),
        .cfg           (cfg),
        .ext_en        (ext_en),
        .arm           (arm),
        .timestamp     (timestamp),
        .samples_valid (samples_valid),
        .tdc_samples   (tdc_samples),
        .trig_samples  (trig_samples),
        .out_word      (out_word),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .event_count   (event_count),
        .lost_count    (lost_count)
    );

    always #10 DV_CLK = ~DV_CLK;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input tdc_word_u act, input tdc_word_u exp);
        if (act !== exp) begin
            abort_run($sformatf("ERROR: %s got 0x%08h expected 0x%08h", name, act, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        if (act !== exp) begin
            abort_run($sformatf("ERROR: %s got 0x%08h expected 0x%08h", name, act, exp));
        end
    endtask

    // Latest trigger rising edge at or before the TDC rising edge
    function automatic int ref_dist();
        int rise;
        int t;
        rise = -1;
        t    = -1;
        for (int i = 0; i < tdc_bits.size(); i++) begin
            if (tdc_bits[i] && rise < 0) begin
                rise = i;
            end
        end
        for (int i = 0; i <= rise; i++) begin
            if (trig_bits[i] && (i == 0 || !trig_bits[i-1])) begin
                t = i;
            end
        end
        if (t < 0) begin
            return 255;
        end
        return (rise - t > 254) ? 254 : rise - t;
    endfunction

    function automatic tdc_word_u tdc_ref(input tdc_cfg_t c, input logic [15:0] ts,
                                          input logic [31:0] n_evt);
        int        rise;
        int        fall;
        int        width;
        bit        dbl;
        tdc_word_u r;
        rise = -1;
        fall = -1;
        dbl  = 1'b0;
        for (int i = 0; i < tdc_bits.size(); i++) begin
            if (tdc_bits[i]) begin
                if (rise < 0) begin
                    rise = i;
                end else if (fall >= 0 && i / SAMPLE_BITS == fall / SAMPLE_BITS) begin
                    dbl = 1'b1;  // Second pulse in the word that ends the first
                end
            end else if (rise >= 0 && fall < 0) begin
                fall = i;
            end
        end
        width = fall - rise;
        if (width > 4095) begin
            width = 4095;
        end
        if (dbl) begin
            width = 0;
        end
        r = {DATA_ID, c.write_ts ? ts : n_evt[15:0], 12'(width)};
        if (c.trig_dist) begin
            r[27:20] = 8'(ref_dist());
        end
        return r;
    endfunction

    // One pulse with idle lead and tail, optional trigger trig_d samples earlier
    task automatic send_pulse(input int lead, input int width, input bit dbl,
                              input int trig_d, input bit measured, input bit do_arm);
        int          nw;
        logic [15:0] ts;
        tdc_bits.delete();
        trig_bits.delete();
        for (int i = 0; i < lead; i++) tdc_bits.push_back(1'b0);
        for (int i = 0; i < width; i++) tdc_bits.push_back(1'b1);
        if (dbl) begin
            tdc_bits.push_back(1'b0);
            tdc_bits.push_back(1'b0);
            for (int i = 0; i < 3; i++) tdc_bits.push_back(1'b1);
        end
        nw = tdc_bits.size() / SAMPLE_BITS + 5;  // Four idle words after the pulse
        while (tdc_bits.size() < nw * SAMPLE_BITS) tdc_bits.push_back(1'b0);
        for (int i = 0; i < nw * SAMPLE_BITS; i++) trig_bits.push_back(1'b0);
        if (trig_d > 0) begin
            trig_bits[lead - trig_d]     = 1'b1;
            trig_bits[lead - trig_d + 1] = 1'b1;
        end
        ts = 16'($urandom);
        if (measured) begin
            if (!(cfg.drop_trig_err && ref_dist() == 255)) begin
                exp_q.push_back(tdc_ref(cfg, ts, n_events));
            end
            n_events++;
        end
        for (int w = 0; w < nw; w++) begin
            @(negedge DV_CLK);
            timestamp = ts;
            arm       = do_arm && (w == 0);
            for (int k = 0; k < SAMPLE_BITS; k++) begin
                tdc_samples[SAMPLE_BITS-1-k]  = tdc_bits[w*SAMPLE_BITS + k];
                trig_samples[SAMPLE_BITS-1-k] = trig_bits[w*SAMPLE_BITS + k];
            end
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge DV_CLK);
        repeat (6) @(negedge DV_CLK);                    // Room for a stray record
        check_count("event_count", event_count, n_events);
    endtask

    // Compare on every output handshake
    always @(posedge DV_CLK) begin
        if (!RST_SYNC && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("A record came out of the DUT when none was expected");
            end else begin
                check_word("out_word", out_word, exp_q.pop_front());
            end
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge DV_CLK);
        abort_run("Timeout, the tests did not finish in the allowed number of cycles");
    end

    initial begin
        void'($urandom(18313));
        DV_CLK        = 1'b0;
        RST_SYNC      = 1'b1;
        cfg           = '0;
        ext_en        = 1'b0;
        arm           = 1'b0;
        timestamp     = 16'd0;
        samples_valid = 1'b0;
        tdc_samples   = '0;
        trig_samples  = '0;
        out_ready     = 1'b1;
        n_events      = 32'd0;
        repeat (3) @(negedge DV_CLK);
        RST_SYNC      = 1'b0;
        samples_valid = 1'b1;
        check_count("event_count", event_count, 32'd0);
        check_count("lost_count", {24'd0, lost_count}, 32'd0);

        // Random single pulses, event-counter format
        cfg.enable = 1'b1;
        for (int p = 0; p < 20; p++) begin
            send_pulse(16 + int'($urandom % 40), 1 + int'($urandom % 200), 1'b0, 0, 1'b1, 1'b0);
        end
        drain();

        // Width overflow and a double pulse in one word
        send_pulse(20, 5000, 1'b0, 0, 1'b1, 1'b0);
        send_pulse(37, 4200, 1'b0, 0, 1'b1, 1'b0);
        send_pulse(34, 3, 1'b1, 0, 1'b1, 1'b0);
        drain();

        // Timestamp format with distance overlay
        cfg.write_ts  = 1'b1;
        cfg.trig_dist = 1'b1;
        send_pulse(30, 12, 1'b0, 5, 1'b1, 1'b0);
        send_pulse(60, 40, 1'b0, 37, 1'b1, 1'b0);
        send_pulse(310, 25, 1'b0, 300, 1'b1, 1'b0);
        send_pulse(25, 9, 1'b0, 0, 1'b1, 1'b0);
        drain();
        cfg.drop_trig_err = 1'b1;
        send_pulse(25, 9, 1'b0, 0, 1'b1, 1'b0);
        send_pulse(45, 17, 1'b0, 20, 1'b1, 1'b0);
        drain();

        // Arm mode, then external enable
        cfg          = '0;
        cfg.enable   = 1'b1;
        cfg.arm_mode = 1'b1;
        send_pulse(40, 10, 1'b0, 0, 1'b0, 1'b0);
        send_pulse(40, 10, 1'b0, 0, 1'b1, 1'b1);
        send_pulse(40, 10, 1'b0, 0, 1'b0, 1'b0);
        drain();
        cfg          = '0;
        cfg.ext_mode = 1'b1;
        send_pulse(40, 14, 1'b0, 0, 1'b0, 1'b0);
        ext_en = 1'b1;
        send_pulse(40, 14, 1'b0, 0, 1'b1, 1'b0);
        drain();
        ext_en = 1'b0;

        // Back-pressure, records past the FIFO depth are lost
        cfg        = '0;
        cfg.enable = 1'b1;
        out_ready  = 1'b0;
        for (int p = 0; p < FIFO_DEPTH + 4; p++) begin
            send_pulse(20 + p, 5 + p, 1'b0, 0, 1'b1, 1'b0);
        end
        repeat (8) @(negedge DV_CLK);
        check_count("lost_count", {24'd0, lost_count}, 32'd4);
        check_count("event_count", event_count, n_events);
        repeat (4) void'(exp_q.pop_back());
        out_ready = 1'b1;
        drain();
        check_count("lost_count", {24'd0, lost_count}, 32'd4);

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== tdc_core_top.sv ====
// TDC core top level, scan, measure, pack and queue stages in one clock domain
`timescale 1ns/1ps

module tdc_core_top #(
    parameter int SAMPLE_BITS = 16,
    parameter int FIFO_DEPTH  = 8
) (
    input  logic                   DV_CLK,
    input  logic                   RST_SYNC,
    input  tdc_pkg::tdc_cfg_t      cfg,
    input  logic                   ext_en,
    input  logic                   arm,
    input  logic [15:0]            timestamp,
    input  logic                   samples_valid,
    input  logic [SAMPLE_BITS-1:0] tdc_samples,
    input  logic [SAMPLE_BITS-1:0] trig_samples,
    output tdc_pkg::tdc_word_u     out_word,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [31:0]            event_count,
    output logic [7:0]             lost_count
);
    import tdc_pkg::*;

    scan_t     tdc_scan;
    scan_t     trig_scan;
    logic      scan_valid;
    meas_t     meas;
    tdc_word_u rec_word;
    logic      rec_valid;
    logic      fifo_full;

    tdc_word_scan #(.SAMPLE_BITS(SAMPLE_BITS)) u_tdc_scan (
        .DV_CLK     (DV_CLK),
        .RST_SYNC   (RST_SYNC),
        .samples    (tdc_samples),
        .in_valid   (samples_valid),
        .scan       (tdc_scan),
        .scan_valid (scan_valid)
    );

    // Same timing as the TDC scanner, its valid is not needed
    tdc_word_scan #(.SAMPLE_BITS(SAMPLE_BITS)) u_trig_scan (
        .DV_CLK     (DV_CLK),
        .RST_SYNC   (RST_SYNC),
        .samples    (trig_samples),
        .in_valid   (samples_valid),
        .scan       (trig_scan),
        .scan_valid ()
    );

    tdc_measure #(.SAMPLE_BITS(SAMPLE_BITS)) u_measure (
        .DV_CLK     (DV_CLK),
        .RST_SYNC   (RST_SYNC),
        .cfg        (cfg),
        .ext_en     (ext_en),
        .arm        (arm),
        .timestamp  (timestamp),
        .tdc_scan   (tdc_scan),
        .trig_scan  (trig_scan),
        .scan_valid (scan_valid),
        .meas       (meas)
    );

    tdc_pack u_pack (
        .DV_CLK      (DV_CLK),
        .RST_SYNC    (RST_SYNC),
        .cfg         (cfg),
        .meas        (meas),
        .fifo_full   (fifo_full),
        .rec_word    (rec_word),
        .rec_valid   (rec_valid),
        .event_count (event_count),
        .lost_count  (lost_count)
    );

    tdc_out_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_out_fifo (
        .DV_CLK    (DV_CLK),
        .RST_SYNC  (RST_SYNC),
        .wr_word   (rec_word),
        .wr_en     (rec_valid),
        .full      (fifo_full),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// ==== tdc_out_fifo.sv ====
// Synchronous record FIFO with valid/ready read side
`timescale 1ns/1ps

module tdc_out_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic               DV_CLK,
    input  logic               RST_SYNC,
    input  tdc_pkg::tdc_word_u wr_word,
    input  logic               wr_en,
    output logic               full,
    output tdc_pkg::tdc_word_u out_word,
    output logic               out_valid,
    input  logic               out_ready
);
    import tdc_pkg::*;

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    tdc_word_u     mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic [AW:0]   count_next;
    logic          do_wr;
    logic          do_rd;

    assign do_wr      = wr_en && (count != (AW+1)'(FIFO_DEPTH));
    assign do_rd      = out_valid && out_ready;
    assign count_next = count + (AW+1)'(do_wr) - (AW+1)'(do_rd);

    // Occupancy after this cycle, so a write decided now still fits next cycle
    assign full      = (count_next == (AW+1)'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_word  = mem[rd_ptr];

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            count <= count_next;
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_word;
        end
    end

endmodule

// ==== tdc_pack.sv ====
// Record formatter with event and lost-record counters
`timescale 1ns/1ps

module tdc_pack (
    input  logic               DV_CLK,
    input  logic               RST_SYNC,
    input  tdc_pkg::tdc_cfg_t  cfg,
    input  tdc_pkg::meas_t     meas,
    input  logic               fifo_full,
    output tdc_pkg::tdc_word_u rec_word,
    output logic               rec_valid,
    output logic [31:0]        event_count,
    output logic [7:0]         lost_count
);
    import tdc_pkg::*;

    tdc_word_u rec_next;
    logic      trig_reject;
    logic      keep;

    assign trig_reject = cfg.drop_trig_err && (meas.trig_dist == DIST_NONE);
    assign keep        = meas.finish && !trig_reject;

    always_comb begin
        rec_next = '0;
        if (cfg.write_ts) begin
            rec_next.ts.id  = DATA_ID;
            rec_next.ts.ts  = meas.timestamp;
            rec_next.ts.tdc = meas.tdc_val;
        end else begin
            rec_next.evt.id      = DATA_ID;
            rec_next.evt.evt_cnt = event_count[15:0];  // Count before this event
            rec_next.evt.tdc     = meas.tdc_val;
        end
        // Bits 27:20 sit in the upper middle field of either view
        if (cfg.trig_dist) begin
            rec_next.evt.evt_cnt[15:8] = meas.trig_dist;
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            rec_valid   <= 1'b0;
            event_count <= 32'd0;
            lost_count  <= 8'd0;
        end else begin
            rec_valid <= keep && !fifo_full;
            if (meas.finish) begin
                event_count <= event_count + 32'd1;
            end
            if (keep && fifo_full && (lost_count != 8'hFF)) begin
                lost_count <= lost_count + 8'd1;  // Saturates at 255
            end
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (keep) begin
            rec_word <= rec_next;
        end
    end

endmodule

// ==== tdc_measure.sv ====
// Pulse measurement FSM with width accumulation and trigger distance
`timescale 1ns/1ps

module tdc_measure #(
    parameter int SAMPLE_BITS = 16
) (
    input  logic              DV_CLK,
    input  logic              RST_SYNC,
    input  tdc_pkg::tdc_cfg_t cfg,
    input  logic              ext_en,
    input  logic              arm,
    input  logic [15:0]       timestamp,
    input  tdc_pkg::scan_t    tdc_scan,
    input  tdc_pkg::scan_t    trig_scan,
    input  logic              scan_valid,
    output tdc_pkg::meas_t    meas
);
    import tdc_pkg::*;

    typedef enum logic [1:0] {IDLE, ARMED, COUNT} state_t;

    state_t      state;
    state_t      state_n;
    logic        en_eff;
    logic        arm_q;
    logic        arm_edge;
    logic        tdc_err;
    logic        trig_dbl;
    logic        pulse_open;
    logic        start;
    logic        finish;
    logic [6:0]  rise_end;
    logic [12:0] width_sum;
    logic [11:0] width_acc;
    logic [11:0] acc_q;
    logic [11:0] tdc_val_n;
    logic [15:0] ts_start;
    logic        trig_seen;
    logic        trig_bad;
    logic [7:0]  dist_cnt;
    logic [8:0]  dist_sum;
    logic [8:0]  dist_step;
    logic [7:0]  dist_now;
    logic [7:0]  dist_lat;
    logic        finish_q;
    logic [11:0] tdc_val_q;
    logic [7:0]  dist_q;
    logic [15:0] ts_q;

    assign en_eff   = cfg.enable | (cfg.ext_mode & ext_en);
    assign arm_edge = arm & ~arm_q;
    assign tdc_err  = (tdc_scan.all_ones != tdc_scan.ones);    // Second pulse in word
    assign trig_dbl = (trig_scan.all_ones != trig_scan.ones);

    // Pulse still high at the end of its start word
    assign rise_end   = {1'b0, tdc_scan.rise_pos} + {1'b0, tdc_scan.ones};
    assign pulse_open = (rise_end == 7'(SAMPLE_BITS));

    assign width_sum = {1'b0, acc_q} + 13'(tdc_scan.ones);
    assign width_acc = (width_sum > {1'b0, TDC_MAX}) ? TDC_MAX : width_sum[11:0];

    always_comb begin
        state_n = state;
        start   = 1'b0;
        finish  = 1'b0;
        case (state)
            IDLE: begin
                if (en_eff) begin
                    if (cfg.arm_mode) begin
                        if (arm_edge) begin
                            state_n = ARMED;
                        end
                    end else if (scan_valid && tdc_scan.has_rise) begin
                        start = 1'b1;
                    end
                end
            end
            ARMED: begin
                if (!en_eff) begin
                    state_n = IDLE;
                end else if (scan_valid && tdc_scan.has_rise) begin
                    start = 1'b1;
                end
            end
            COUNT: begin
                if (!en_eff || (scan_valid && tdc_scan.has_zero)) begin
                    state_n = IDLE;
                    finish  = 1'b1;
                end
            end
            default: state_n = IDLE;
        endcase
        if (start) begin
            if (tdc_err || !pulse_open) begin  // Pulse ends inside its start word
                state_n = IDLE;
                finish  = 1'b1;
            end else begin
                state_n = COUNT;
            end
        end
    end

    always_comb begin
        if (state == COUNT) begin
            tdc_val_n = !en_eff ? acc_q : (tdc_err ? 12'd0 : width_acc);
        end else begin
            tdc_val_n = tdc_err ? 12'd0 : 12'(tdc_scan.ones);
        end
    end

    // Distance from latest trigger edge to the TDC rising edge
    assign dist_sum  = {1'b0, dist_cnt} + 9'(tdc_scan.rise_pos);
    assign dist_step = {1'b0, dist_cnt} + 9'(SAMPLE_BITS);

    always_comb begin
        if (trig_scan.has_rise && (trig_scan.rise_pos <= tdc_scan.rise_pos)) begin
            dist_now = trig_dbl ? DIST_NONE : {2'b00, tdc_scan.rise_pos - trig_scan.rise_pos};
        end else if (trig_seen && !trig_bad) begin
            dist_now = (dist_sum > {1'b0, DIST_MAX}) ? DIST_MAX : dist_sum[7:0];
        end else begin
            dist_now = DIST_NONE;
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            state     <= IDLE;
            arm_q     <= 1'b0;
            trig_seen <= 1'b0;
            trig_bad  <= 1'b0;
            finish_q  <= 1'b0;
        end else begin
            state    <= state_n;
            arm_q    <= arm;
            finish_q <= finish;
            if (finish) begin                   // Triggers are consumed per record
                trig_seen <= 1'b0;
                trig_bad  <= 1'b0;
            end else if (scan_valid && trig_scan.has_rise) begin
                trig_seen <= 1'b1;
                trig_bad  <= trig_dbl;
            end
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (start) begin
            acc_q    <= 12'(tdc_scan.ones);
            ts_start <= timestamp;
            dist_lat <= dist_now;
        end else if (state == COUNT && scan_valid) begin
            acc_q <= width_acc;
        end
        if (scan_valid) begin
            if (trig_scan.has_rise) begin
                dist_cnt <= 8'(SAMPLE_BITS) - 8'(trig_scan.rise_pos);
            end else begin
                dist_cnt <= (dist_step > {1'b0, DIST_MAX}) ? DIST_MAX : dist_step[7:0];
            end
        end
        if (finish) begin
            tdc_val_q <= tdc_val_n;
            dist_q    <= start ? dist_now : dist_lat;
            ts_q      <= start ? timestamp : ts_start;
        end
    end

    assign meas.tdc_val   = tdc_val_q;
    assign meas.trig_dist = dist_q;
    assign meas.timestamp = ts_q;
    assign meas.finish    = finish_q;
    assign meas.spare     = 4'd0;

endmodule

// ==== tdc_word_scan.sv ====
// Sample word scanner, reduces one oversampled word to a pulse summary
`timescale 1ns/1ps

module tdc_word_scan #(
    parameter int SAMPLE_BITS = 16
) (
    input  logic                   DV_CLK,
    input  logic                   RST_SYNC,
    input  logic [SAMPLE_BITS-1:0] samples,
    input  logic                   in_valid,
    output tdc_pkg::scan_t         scan,
    output logic                   scan_valid
);
    import tdc_pkg::*;

    logic             prev_last;  // Latest sample of the previous word
    logic [CNT_W-1:0] ones_c;
    logic [CNT_W-1:0] all_c;
    logic [CNT_W-1:0] rise_c;
    logic             rise_f;
    logic             fall_f;
    logic             zero_c;
    logic             prev_c;

    // Walk from the earliest sample (MSB) to the latest (bit 0)
    always_comb begin
        ones_c = '0;
        all_c  = '0;
        rise_c = '0;
        rise_f = 1'b0;
        fall_f = 1'b0;
        zero_c = 1'b0;
        prev_c = prev_last;
        for (int i = SAMPLE_BITS - 1; i >= 0; i--) begin
            if (samples[i]) begin
                all_c = all_c + 1'b1;
                if (!fall_f) begin
                    ones_c = ones_c + 1'b1;
                end
                if (!prev_c && !rise_f) begin
                    rise_f = 1'b1;
                    rise_c = CNT_W'(SAMPLE_BITS - 1 - i);  // Samples before the edge
                end
            end else begin
                zero_c = 1'b1;
                if (prev_c) begin
                    fall_f = 1'b1;  // Stop counting ones
                end
            end
            prev_c = samples[i];
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (RST_SYNC) begin
            prev_last  <= 1'b0;
            scan_valid <= 1'b0;
        end else begin
            scan_valid <= in_valid;
            if (in_valid) begin
                prev_last <= samples[0];
            end
        end
    end

    always_ff @(posedge DV_CLK) begin
        if (in_valid) begin
            scan.ones     <= ones_c;
            scan.all_ones <= all_c;
            scan.rise_pos <= rise_c;
            scan.has_rise <= rise_f;
            scan.has_zero <= zero_c;
        end
    end

endmodule

// ==== tdc_pkg.sv ====
// TDC core package holding configuration, scan, measurement and record types
package tdc_pkg;

    // Width of the per-word sample counters, enough for 32 samples
    localparam int CNT_W = 6;

    localparam logic [3:0]  DATA_ID   = 4'b0100;
    localparam logic [11:0] TDC_MAX   = 12'd4095;  // Width overflow bin
    localparam logic [7:0]  DIST_NONE = 8'd255;    // No trigger or trigger error
    localparam logic [7:0]  DIST_MAX  = 8'd254;    // Distance overflow bin

    // Static configuration, enable in bit 0
    typedef struct packed {
        logic drop_trig_err;  // Skip records with distance DIST_NONE
        logic trig_dist;      // Overlay distance on bits 27:20
        logic write_ts;       // Timestamp instead of event count
        logic arm_mode;       // Measure only after an arm edge
        logic ext_mode;       // ext_en also enables
        logic enable;
    } tdc_cfg_t;

    // Summary of one sample word, earliest sample first
    typedef struct packed {
        logic [CNT_W-1:0] ones;      // High samples before first falling edge
        logic [CNT_W-1:0] all_ones;  // All high samples
        logic [CNT_W-1:0] rise_pos;  // Samples before first rising edge
        logic             has_rise;
        logic             has_zero;
    } scan_t;

    // Result of one finished pulse
    typedef struct packed {
        logic [11:0] tdc_val;
        logic [7:0]  trig_dist;
        logic [15:0] timestamp;
        logic        finish;     // One-cycle strobe
        logic [3:0]  spare;
    } meas_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [15:0] evt_cnt;
        logic [11:0] tdc;
    } evt_view_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [15:0] ts;
        logic [11:0] tdc;
    } ts_view_t;

    // Output record, read as event-counter or timestamp format
    typedef union packed {
        evt_view_t evt;
        ts_view_t  ts;
    } tdc_word_u;

endpackage
